// File: Bender.yml
package:
  name: ooo_issue

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv32i_types.sv
      - instr_queue.sv
      - instr_decode.sv
      - issue.sv
      - rs_execute.sv
      - rob.sv
      - ooo_issue_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ooo_issue.sv

// File: instr_decode.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module instr_decode (
    input  rv32i_types::rv32i_instr_t  word,
    output rv32i_types::rv32i_opcode_t opcode,
    output logic [6:0]                 funct7,
    output logic [4:0]                 rd,
    output rv32i_types::unit_class_t   unit
);
    import rv32i_types::*;

    // opcode sits in the same bits in both layouts
    always_comb begin
        if (word.s_view.opcode == store_opcode) begin
            opcode = word.s_view.opcode;
        end else begin
            opcode = word.r_view.opcode;
        end
    end

    assign funct7 = word.r_view.funct7;

    // class follows the routing in the issue logic
    always_comb begin
        rd   = word.r_view.rd;
        unit = unit_none;
        case (opcode)
            lui_opcode, auipc_opcode, imm_opcode: begin
                unit = unit_alu;
            end
            reg_opcode: begin
                unit = (funct7 == `MULTIPLY_FUNCT7) ? unit_mul : unit_alu;
            end
            br_opcode, jal_opcode, jalr_opcode: begin
                unit = unit_branch;
                // branches retire without a register write
                rd   = '0;
            end
            load_opcode: begin
                unit = unit_load;
            end
            store_opcode: begin
                unit = unit_store;
                // bits 11:7 are imm_lo here, not a destination
                rd   = '0;
            end
            default: begin
                unit = unit_none;
            end
        endcase
    end

endmodule

// File: instr_queue.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module instr_queue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  rv32i_types::rv32i_instr_t push_word,
    input  logic                      pop,
    output rv32i_types::rv32i_instr_t head_word,
    output logic                      valid,
    output logic                      full
);
    import rv32i_types::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    rv32i_instr_t     mem [`IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // pushes into a full queue are dropped
    assign do_push   = push && !full;
    assign do_pop    = pop && valid;
    assign valid     = (count != '0);
    assign full      = (count == CNT_W'(`IQ_DEPTH));
    assign head_word = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count as is
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: issue.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module issue (
    // instruction queue head
    input  logic                       instr_valid,
    input  logic                       instr_ready,
    input  rv32i_types::rv32i_opcode_t opcode,
    input  logic [6:0]                 funct7,
    // station occupancy
    input  logic                       alu_rs_full,
    input  logic                       mul_rs_full,
    input  logic                       branch_rs_full,
    input  logic                       load_rs_full,
    input  logic                       store_rs_full,
    // rob occupancy
    input  logic                       rob_full,
    // queue pop
    output logic                       instr_pop,
    // station strobes
    output logic                       alu_rs_issue,
    output logic                       mul_rs_issue,
    output logic                       branch_rs_issue,
    output logic                       load_rs_issue,
    output logic                       store_rs_issue,
    // rob allocate
    output logic                       rob_push,
    // scoreboard update
    output logic                       issue_valid
);
    import rv32i_types::*;

    logic head_ok;
    logic is_alu;
    logic is_mul;
    logic is_branch;
    logic is_load;
    logic is_store;

    // a head instruction may only leave when the rob has a slot
    assign head_ok = !rob_full && instr_valid && instr_ready;

    assign is_mul    = (opcode == reg_opcode) && (funct7 == `MULTIPLY_FUNCT7);
    assign is_alu    = (opcode == lui_opcode) || (opcode == auipc_opcode) ||
                       (opcode == imm_opcode) ||
                       ((opcode == reg_opcode) && (funct7 != `MULTIPLY_FUNCT7));
    assign is_branch = (opcode == br_opcode) || (opcode == jal_opcode) ||
                       (opcode == jalr_opcode);
    assign is_load   = (opcode == load_opcode);
    assign is_store  = (opcode == store_opcode);

    always_comb begin
        alu_rs_issue    = 1'b0;
        mul_rs_issue    = 1'b0;
        branch_rs_issue = 1'b0;
        load_rs_issue   = 1'b0;
        store_rs_issue  = 1'b0;
        if (head_ok) begin
            // the classes are disjoint, so at most one strobe fires
            if (is_alu && !alu_rs_full) begin
                alu_rs_issue = 1'b1;
            end
            if (is_mul && !mul_rs_full) begin
                mul_rs_issue = 1'b1;
            end
            if (is_branch && !branch_rs_full) begin
                branch_rs_issue = 1'b1;
            end
            if (is_load && !load_rs_full) begin
                load_rs_issue = 1'b1;
            end
            if (is_store && !store_rs_full) begin
                store_rs_issue = 1'b1;
            end
        end
    end

    // pop, rob allocate and scoreboard follow any strobe
    always_comb begin
        instr_pop   = alu_rs_issue || mul_rs_issue || branch_rs_issue ||
                      load_rs_issue || store_rs_issue;
        rob_push    = instr_pop;
        issue_valid = instr_pop;
    end

endmodule

// File: ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// funct7 that selects the M extension on reg_opcode
`define MULTIPLY_FUNCT7 7'b0000001

// buffer sizes
`define ROB_DEPTH 4
`define ROB_TAG_W 2
`define IQ_DEPTH 8
`define RS_DEPTH 2

// cycles from issue to done, per station
`define LAT_ALU 1
`define LAT_MUL 4
`define LAT_BRANCH 1
`define LAT_LOAD 3
`define LAT_STORE 2

`endif

// File: ooo_issue.f
+incdir+.
rv32i_types.sv
instr_queue.sv
instr_decode.sv
issue.sv
rs_execute.sv
rob.sv
ooo_issue_core.sv
tb_ooo_issue.sv

// File: ooo_issue_core.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_issue_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_push,
    input  rv32i_types::rv32i_instr_t instr_word,
    output logic                      iq_full,
    output logic                      alu_rs_issue,
    output logic                      mul_rs_issue,
    output logic                      branch_rs_issue,
    output logic                      load_rs_issue,
    output logic                      store_rs_issue,
    output logic                      issue_valid,
    output logic                      commit_valid,
    output logic [4:0]                commit_rd,
    output rv32i_types::unit_class_t  commit_class
);
    import rv32i_types::*;

    rv32i_instr_t          head_word;
    rv32i_opcode_t         opcode;
    unit_class_t           unit;
    logic [6:0]            funct7;
    logic [4:0]            rd;
    logic                  instr_valid;
    logic                  instr_ready;
    logic                  instr_pop;
    logic                  rob_push;
    logic                  rob_full;
    logic [`ROB_TAG_W-1:0] alloc_tag;
    logic                  alu_rs_full;
    logic                  mul_rs_full;
    logic                  branch_rs_full;
    logic                  load_rs_full;
    logic                  store_rs_full;
    logic [4:0]            done_valid;
    logic [`ROB_TAG_W-1:0] alu_done_tag;
    logic [`ROB_TAG_W-1:0] mul_done_tag;
    logic [`ROB_TAG_W-1:0] branch_done_tag;
    logic [`ROB_TAG_W-1:0] load_done_tag;
    logic [`ROB_TAG_W-1:0] store_done_tag;

    // no downstream stall on the queue head
    assign instr_ready = 1'b1;

    instr_queue u_iq (
        .clk(clk), .rst_n(rst_n), .push(instr_push), .push_word(instr_word), .pop(instr_pop),
        .head_word(head_word), .valid(instr_valid), .full(iq_full)
    );

    instr_decode u_decode (
        .word(head_word), .opcode(opcode), .funct7(funct7), .rd(rd), .unit(unit)
    );

    issue u_issue (
        .instr_valid(instr_valid), .instr_ready(instr_ready), .opcode(opcode), .funct7(funct7),
        .alu_rs_full(alu_rs_full), .mul_rs_full(mul_rs_full),
        .branch_rs_full(branch_rs_full), .load_rs_full(load_rs_full),
        .store_rs_full(store_rs_full), .rob_full(rob_full), .instr_pop(instr_pop),
        .alu_rs_issue(alu_rs_issue), .mul_rs_issue(mul_rs_issue),
        .branch_rs_issue(branch_rs_issue), .load_rs_issue(load_rs_issue),
        .store_rs_issue(store_rs_issue), .rob_push(rob_push), .issue_valid(issue_valid)
    );

    // done_valid bits run alu, mul, branch, load and store from bit 0 up
    rs_execute #(.LATENCY(`LAT_ALU)) u_alu_rs (
        .clk(clk), .rst_n(rst_n), .issue(alu_rs_issue), .issue_tag(alloc_tag),
        .full(alu_rs_full), .done(done_valid[0]), .done_tag(alu_done_tag)
    );

    rs_execute #(.LATENCY(`LAT_MUL)) u_mul_rs (
        .clk(clk), .rst_n(rst_n), .issue(mul_rs_issue), .issue_tag(alloc_tag),
        .full(mul_rs_full), .done(done_valid[1]), .done_tag(mul_done_tag)
    );

    rs_execute #(.LATENCY(`LAT_BRANCH)) u_branch_rs (
        .clk(clk), .rst_n(rst_n), .issue(branch_rs_issue), .issue_tag(alloc_tag),
        .full(branch_rs_full), .done(done_valid[2]), .done_tag(branch_done_tag)
    );

    rs_execute #(.LATENCY(`LAT_LOAD)) u_load_rs (
        .clk(clk), .rst_n(rst_n), .issue(load_rs_issue), .issue_tag(alloc_tag),
        .full(load_rs_full), .done(done_valid[3]), .done_tag(load_done_tag)
    );

    rs_execute #(.LATENCY(`LAT_STORE)) u_store_rs (
        .clk(clk), .rst_n(rst_n), .issue(store_rs_issue), .issue_tag(alloc_tag),
        .full(store_rs_full), .done(done_valid[4]), .done_tag(store_done_tag)
    );

    rob u_rob (
        .clk(clk), .rst_n(rst_n), .push(rob_push), .push_rd(rd), .push_class(unit),
        .alloc_tag(alloc_tag), .full(rob_full), .done_valid(done_valid),
        .done_tag0(alu_done_tag), .done_tag1(mul_done_tag), .done_tag2(branch_done_tag),
        .done_tag3(load_done_tag), .done_tag4(store_done_tag),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_class(commit_class)
    );

endmodule

// File: ooo_issue_golden.txt
# columns: instruction word (hex), unit class (0 alu 1 mul 2 branch 3 load 4 store), rd
# rd is the expected commit_rd, zero for stores and branches
00500093 0 1
00308113 0 2
123451B7 0 3
00001217 0 4
002082B3 0 5
02208333 1 6
401103B3 0 7
0040A403 3 8
0020A423 4 0
00208463 2 0
010000EF 2 0
00008067 2 0
00012483 3 9
02208533 1 10
022085B3 1 11
02208633 1 12
022086B3 1 13
02208733 1 14
022087B3 1 15
00100813 0 16
00200893 0 17
00300913 0 18
011809B3 0 19
00312023 4 0
00C02A03 3 20
00019663 2 0
02418AB3 1 21
FFFF8F93 0 31

// File: rob.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rob (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  logic [4:0]               push_rd,
    input  rv32i_types::unit_class_t push_class,
    output logic [`ROB_TAG_W-1:0]    alloc_tag,
    output logic                     full,
    input  logic [4:0]               done_valid,
    input  logic [`ROB_TAG_W-1:0]    done_tag0,
    input  logic [`ROB_TAG_W-1:0]    done_tag1,
    input  logic [`ROB_TAG_W-1:0]    done_tag2,
    input  logic [`ROB_TAG_W-1:0]    done_tag3,
    input  logic [`ROB_TAG_W-1:0]    done_tag4,
    output logic                     commit_valid,
    output logic [4:0]               commit_rd,
    output rv32i_types::unit_class_t commit_class
);
    import rv32i_types::*;

    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    logic [4:0]            entry_rd    [`ROB_DEPTH];
    unit_class_t           entry_class [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] entry_busy;
    logic [`ROB_DEPTH-1:0] entry_done;
    logic [`ROB_TAG_W-1:0] head_ptr;
    logic [`ROB_TAG_W-1:0] tail_ptr;
    logic [CNT_W-1:0]      count;
    logic [`ROB_TAG_W-1:0] done_tags [5];
    logic                  head_hit;
    logic                  do_push;
    logic                  do_commit;

    assign done_tags[0] = done_tag0;
    assign done_tags[1] = done_tag1;
    assign done_tags[2] = done_tag2;
    assign done_tags[3] = done_tag3;
    assign done_tags[4] = done_tag4;

    assign alloc_tag = tail_ptr;
    assign full      = (count == CNT_W'(`ROB_DEPTH));
    assign do_push   = push && !full;

    // head can retire on the edge that sets its done bit
    always_comb begin
        head_hit = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (done_valid[i] && (done_tags[i] == head_ptr)) begin
                head_hit = 1'b1;
            end
        end
    end

    assign do_commit = entry_busy[head_ptr] && (entry_done[head_ptr] || head_hit);

    // pointers wrap with the tag width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_busy   <= '0;
            entry_done   <= '0;
            head_ptr     <= '0;
            tail_ptr     <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (done_valid[i]) begin
                    entry_done[done_tags[i]] <= 1'b1;
                end
            end
            if (do_commit) begin
                entry_busy[head_ptr] <= 1'b0;
                entry_done[head_ptr] <= 1'b0;
                head_ptr             <= head_ptr + 1'b1;
            end
            if (do_push) begin
                entry_busy[tail_ptr] <= 1'b1;
                entry_done[tail_ptr] <= 1'b0;
                tail_ptr             <= tail_ptr + 1'b1;
            end
            commit_valid <= do_commit;
            case ({do_push, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entry_rd[tail_ptr]    <= push_rd;
            entry_class[tail_ptr] <= push_class;
        end
        if (do_commit) begin
            commit_rd    <= entry_rd[head_ptr];
            commit_class <= entry_class[head_ptr];
        end
    end

endmodule

// File: rs_execute.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rs_execute #(
    parameter int LATENCY = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  logic [`ROB_TAG_W-1:0] issue_tag,
    output logic                  full,
    output logic                  done,
    output logic [`ROB_TAG_W-1:0] done_tag
);
    localparam int CNT_W = $clog2(`RS_DEPTH + 1);

    logic [LATENCY-1:0]    stage_valid;
    logic [`ROB_TAG_W-1:0] stage_tag [LATENCY];
    logic [CNT_W-1:0]      count;

    // last stage is the completion
    assign done     = stage_valid[LATENCY-1];
    assign done_tag = stage_tag[LATENCY-1];
    assign full     = (count == CNT_W'(`RS_DEPTH));

    // valid bits move one stage per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue;
            for (int i = 1; i < LATENCY; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    // tags travel alongside
    always_ff @(posedge clk) begin
        stage_tag[0] <= issue_tag;
        for (int i = 1; i < LATENCY; i++) begin
            stage_tag[i] <= stage_tag[i-1];
        end
    end

    // in-flight count with issue and done allowed in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({issue, done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rv32i_types.sv
package rv32i_types;

    // base opcodes handled by the issue stage
    typedef enum logic [6:0] {
        lui_opcode   = 7'b0110111,
        auipc_opcode = 7'b0010111,
        imm_opcode   = 7'b0010011,
        reg_opcode   = 7'b0110011,
        br_opcode    = 7'b1100011,
        jal_opcode   = 7'b1101111,
        jalr_opcode  = 7'b1100111,
        load_opcode  = 7'b0000011,
        store_opcode = 7'b0100011
    } rv32i_opcode_t;

    // one instruction word, seen as R-type or as S-type
    typedef union packed {
        struct packed {
            logic [6:0]    funct7;
            logic [4:0]    rs2;
            logic [4:0]    rs1;
            logic [2:0]    funct3;
            logic [4:0]    rd;
            rv32i_opcode_t opcode;
        } r_view;
        struct packed {
            logic [6:0]    imm_hi;
            logic [4:0]    rs2;
            logic [4:0]    rs1;
            logic [2:0]    funct3;
            logic [4:0]    imm_lo;
            rv32i_opcode_t opcode;
        } s_view;
    } rv32i_instr_t;

    // execution unit an instruction is sent to
    typedef enum logic [2:0] {
        unit_alu,
        unit_mul,
        unit_branch,
        unit_load,
        unit_store,
        unit_none
    } unit_class_t;

endpackage

// File: tb_ooo_issue.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module tb_ooo_issue;
    import rv32i_types::*;

    localparam int MAX_WORDS  = 64;
    localparam int WAIT_LIMIT = 200;

    logic         clk;
    logic         rst_n;
    logic         instr_push;
    rv32i_instr_t instr_word;
    logic         iq_full;
    logic         alu_rs_issue;
    logic         mul_rs_issue;
    logic         branch_rs_issue;
    logic         load_rs_issue;
    logic         store_rs_issue;
    logic         issue_valid;
    logic         commit_valid;
    logic [4:0]   commit_rd;
    unit_class_t  commit_class;

    logic [31:0] gold_word  [MAX_WORDS];
    int          gold_class [MAX_WORDS];
    int          gold_rd    [MAX_WORDS];
    int          n_words;
    int          issue_idx;
    int          commit_idx;
    // per unit strobe history with bit 0 as the current cycle
    logic [7:0]  unit_hist  [5];
    int unsigned seed_ret;

    ooo_issue_core u_dut (
        .clk(clk), .rst_n(rst_n), .instr_push(instr_push), .instr_word(instr_word),
        .iq_full(iq_full), .alu_rs_issue(alu_rs_issue), .mul_rs_issue(mul_rs_issue),
        .branch_rs_issue(branch_rs_issue), .load_rs_issue(load_rs_issue),
        .store_rs_issue(store_rs_issue), .issue_valid(issue_valid),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_class(commit_class)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // index follows the class encoding from alu up to store
    function automatic int unit_latency(input int u);
        case (u)
            0:       return `LAT_ALU;
            1:       return `LAT_MUL;
            2:       return `LAT_BRANCH;
            3:       return `LAT_LOAD;
            default: return `LAT_STORE;
        endcase
    endfunction

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] w;
        int          c;
        int          r;
        n_words = 0;
        fd = $fopen("ooo_issue_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open ooo_issue_golden.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // comment and blank lines do not parse
            n = $sscanf(line, "%h %d %d", w, c, r);
            if (n == 3) begin
                if (n_words == MAX_WORDS) begin
                    abort_run("golden file holds too many words");
                end
                gold_word[n_words]  = w;
                gold_class[n_words] = c;
                gold_rd[n_words]    = r;
                n_words++;
            end
        end
        $fclose(fd);
        if (n_words == 0) begin
            abort_run("golden file holds no words");
        end
    endtask

    task automatic drive_word(input int idx);
        int gap;
        int waited;
        gap = $urandom_range(3, 0);
        repeat (gap) @(posedge clk);
        @(negedge clk);
        waited = 0;
        while (iq_full) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout waiting for queue space");
            end
            @(negedge clk);
        end
        @(posedge clk);
        instr_push <= 1'b1;
        instr_word <= gold_word[idx];
        @(posedge clk);
        instr_push <= 1'b0;
    endtask

    task automatic monitor_cycle();
        logic [4:0] strobes;
        int         n_strobe;
        int         strobe_unit;
        int         in_flight;
        strobes  = {store_rs_issue, load_rs_issue, branch_rs_issue, mul_rs_issue, alu_rs_issue};
        n_strobe = $countones(strobes);
        strobe_unit = 0;
        for (int u = 0; u < 5; u++) begin
            unit_hist[u] = {unit_hist[u][6:0], strobes[u]};
            if (strobes[u]) begin
                strobe_unit = u;
            end
            // an issue stays outstanding through its done cycle
            in_flight = 0;
            for (int k = 0; k <= unit_latency(u); k++) begin
                in_flight += unit_hist[u][k];
            end
            if (in_flight > `RS_DEPTH) begin
                abort_run($sformatf("unit %0d has too many issues outstanding", u));
            end
        end
        if (n_strobe > 1) begin
            abort_run("more than one issue strobe high in one cycle");
        end
        check_val("issue_valid", n_strobe, issue_valid);
        if (n_strobe == 1) begin
            if (issue_idx >= n_words) begin
                abort_run("more issues than golden words");
            end
            check_val("issue strobe unit", gold_class[issue_idx], strobe_unit);
            issue_idx++;
        end
        if (commit_valid) begin
            if (commit_idx >= n_words) begin
                abort_run("more commits than golden words");
            end
            check_val("commit_class", gold_class[commit_idx], commit_class);
            check_val("commit_rd", gold_rd[commit_idx], commit_rd);
            commit_idx++;
        end
        if (issue_idx - commit_idx > `ROB_DEPTH) begin
            abort_run("more instructions in flight than ROB entries");
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            monitor_cycle();
        end
    end

    initial begin
        int waited;
        seed_ret   = $urandom(46);
        rst_n      = 1'b0;
        instr_push = 1'b0;
        instr_word = '0;
        issue_idx  = 0;
        commit_idx = 0;
        for (int u = 0; u < 5; u++) begin
            unit_hist[u] = '0;
        end
        load_golden();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // idle state before the first push
        @(negedge clk);
        check_val("issue strobes", 5'b0, {store_rs_issue, load_rs_issue, branch_rs_issue,
                                          mul_rs_issue, alu_rs_issue});
        check_val("issue_valid", 1'b0, issue_valid);
        check_val("commit_valid", 1'b0, commit_valid);
        check_val("iq_full", 1'b0, iq_full);
        for (int i = 0; i < n_words; i++) begin
            drive_word(i);
        end
        waited = 0;
        while (commit_idx < n_words) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout waiting for commit");
            end
            @(posedge clk);
        end
        // quiet tail so a stray commit would still be caught
        repeat (10) @(posedge clk);
        check_val("issue count", n_words, issue_idx);
        check_val("commit count", n_words, commit_idx);
        $display("TESTS PASSED");
        $finish;
    end

endmodule
